// File: src/fbscale_pkg.sv
// fbscale package
// colour, coordinate and bundle types shared by the display pipeline

`default_nettype none

package fbscale_pkg;

    // widths
    localparam int CORDW = 16;         // screen coordinate bits
    localparam int CHANW = 4;          // bits per colour channel
    localparam int CIDXW = 4;          // palette index bits
    localparam int COLRW = 3 * CHANW;  // rgb colour bits

    typedef logic [CORDW-1:0] coord_t;  // unsigned screen coordinate
    typedef logic [CIDXW-1:0] cidx_t;   // indexed colour

    // red in the top nibble, then green, then blue
    typedef logic [COLRW-1:0] colr_t;

    // display timing bundle, all fields registered in display_timing
    typedef struct packed {
        coord_t sx;     // horizontal position
        coord_t sy;     // vertical position
        logic   hsync;  // horizontal sync, active high
        logic   vsync;  // vertical sync, active high
        logic   de;     // data enable, active region
        logic   frame;  // one cycle at sx 0, sy 0
        logic   line;   // one cycle at start of hblank
    } timing_t;

    // video output bundle
    typedef struct packed {
        colr_t colr;
        logic  hsync;
        logic  vsync;
        logic  de;
    } video_t;

    // palette write
    typedef struct packed {
        logic  we;    // write strobe
        cidx_t idx;   // entry to write
        colr_t colr;  // new colour
    } pal_wr_t;

    // line_fetch fill machine
    typedef enum logic {
        LF_IDLE,  // waiting for a line strobe
        LF_FILL   // copying a framebuffer row
    } lf_state_e;

endpackage

`default_nettype wire

// File: src/display_timing.sv
// display timing generator
// screen counters plus sync, data enable and frame/line strobes

`default_nettype none

module display_timing #(
    parameter int H_ACTIVE = 48,  // visible pixels per line
    parameter int H_TOTAL  = 80,  // pixels per line incl. blanking
    parameter int HS_START = 52,  // hsync first pixel
    parameter int HS_END   = 60,  // first pixel after hsync
    parameter int V_ACTIVE = 36,  // visible lines
    parameter int V_TOTAL  = 40,  // lines per frame
    parameter int VS_START = 37,  // vsync first line
    parameter int VS_END   = 39   // first line after vsync
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    output fbscale_pkg::timing_t tim
);
    import fbscale_pkg::*;

    coord_t cnt_x;  // raw horizontal counter
    coord_t cnt_y;  // raw vertical counter
    logic   end_of_line;
    logic   end_of_frame;

    always_comb begin
        end_of_line  = (cnt_x == coord_t'(H_TOTAL - 1));
        end_of_frame = (cnt_y == coord_t'(V_TOTAL - 1));
    end

    // active region first, then blanking
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (end_of_line) begin
            cnt_x <= '0;
            cnt_y <= end_of_frame ? '0 : cnt_y + 1'b1;  // wrap at frame end
        end else begin
            cnt_x <= cnt_x + 1'b1;
        end
    end

    // registered outputs, one cycle behind the counters
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tim <= '0;  // sync and de low until counting starts
        end else begin
            tim.sx    <= cnt_x;
            tim.sy    <= cnt_y;
            tim.hsync <= (cnt_x >= coord_t'(HS_START)) && (cnt_x < coord_t'(HS_END));
            tim.vsync <= (cnt_y >= coord_t'(VS_START)) && (cnt_y < coord_t'(VS_END));
            tim.de    <= (cnt_x < coord_t'(H_ACTIVE)) && (cnt_y < coord_t'(V_ACTIVE));
            tim.frame <= (cnt_x == '0) && (cnt_y == '0);
            tim.line  <= (cnt_x == coord_t'(H_ACTIVE));  // start of hblank
        end
    end

endmodule

`default_nettype wire

// File: src/framebuffer_ram.sv
// indexed-colour framebuffer
// simple dual-port memory, one write port and one registered read port

`default_nettype none

module framebuffer_ram #(
    parameter int FB_WIDTH  = 16,  // pixels per row
    parameter int FB_HEIGHT = 10   // rows
) (
    input  logic                                   clk_sys,
    input  logic                                   we,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] addr_write,
    input  fbscale_pkg::cidx_t                     data_in,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] addr_read,
    output fbscale_pkg::cidx_t                     data_out
);
    import fbscale_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    cidx_t mem [FB_PIXELS];  // one colour index per pixel

    // write port
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, data one cycle after address
    always_ff @(posedge clk_sys) begin
        data_out <= mem[addr_read];  // old data on same-address write
    end

endmodule

`default_nettype wire

// File: src/line_fetch.sv
// line fetch and scaling linebuffer
// fills one framebuffer row during hblank and replays it with h/v repeat

`default_nettype none

module line_fetch #(
    parameter int H_ACTIVE  = 48,
    parameter int H_TOTAL   = 80,
    parameter int V_TOTAL   = 40,
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 10,
    parameter int FB_SCALE  = 3
) (
    input  logic                                   clk_sys,
    input  logic                                   rst_n,
    input  fbscale_pkg::timing_t                   tim,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] fb_rd_addr,
    input  fbscale_pkg::cidx_t                     fb_rd_data,
    output fbscale_pkg::cidx_t                     lb_cidx
);
    import fbscale_pkg::*;

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);
    localparam int COLW     = $clog2(FB_WIDTH);      // linebuffer index
    localparam int SUBW     = $clog2(FB_SCALE + 1);  // repeat counters
    localparam int ROWW     = $clog2(FB_HEIGHT + 1);

    cidx_t           lb_mem [FB_WIDTH];  // one framebuffer row
    lf_state_e       state;
    logic [SUBW-1:0] vsub;       // sub-line of current screen line
    logic [SUBW-1:0] vsub_next;  // sub-line of next screen line
    logic [ROWW-1:0] row_cnt;    // next row to fetch
    logic [ROWW-1:0] fill_row;
    logic            last_line;
    logic            fill_go;
    logic [COLW-1:0] rd_cnt;     // reads issued so far
    logic [COLW-1:0] wr_col;     // linebuffer slot for returning data
    logic            wr_pend;    // ram data valid this cycle
    logic            lb_valid;   // a full row has landed
    logic [COLW-1:0] rp_col;     // replay column, one pixel ahead
    logic [SUBW-1:0] rp_sub;     // horizontal repeat count
    logic            rp_step;

    always_comb begin
        last_line = (tim.sy == coord_t'(V_TOTAL - 1));  // next line wraps to 0
        vsub_next = (last_line || vsub == SUBW'(FB_SCALE - 1)) ? '0 : vsub + 1'b1;
        fill_row  = last_line ? '0 : row_cnt;
        // refill only when the next line starts a new image row
        fill_go   = tim.line && (vsub_next == '0)
                    && (last_line || row_cnt < ROWW'(FB_HEIGHT));
        // step through active pixels, plus the cycle before sx 0
        rp_step   = (tim.sx < coord_t'(H_ACTIVE)) || (tim.sx == coord_t'(H_TOTAL - 1));
    end

    // fill side
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state      <= LF_IDLE;
            vsub       <= '0;
            row_cnt    <= ROWW'(1);  // row 0 belongs to the line after reset
            fb_rd_addr <= '0;
            rd_cnt     <= '0;
            wr_col     <= '0;
            wr_pend    <= 1'b0;
            lb_valid   <= 1'b0;
        end else begin
            if (tim.line) vsub <= vsub_next;
            wr_pend <= (state == LF_FILL);
            wr_col  <= rd_cnt;
            if (wr_pend && wr_col == COLW'(FB_WIDTH - 1)) lb_valid <= 1'b1;
            case (state)
                LF_IDLE: begin
                    if (fill_go) begin
                        state      <= LF_FILL;
                        row_cnt    <= fill_row + 1'b1;
                        fb_rd_addr <= FB_ADDRW'(fill_row) * FB_ADDRW'(FB_WIDTH);  // row base
                        rd_cnt     <= '0;
                    end
                end
                LF_FILL: begin
                    fb_rd_addr <= fb_rd_addr + 1'b1;
                    rd_cnt     <= rd_cnt + 1'b1;
                    if (rd_cnt == COLW'(FB_WIDTH - 1)) state <= LF_IDLE;  // last read out
                end
                default: state <= LF_IDLE;
            endcase
        end
    end

    // ram data lands one cycle after its read
    always_ff @(posedge clk_sys) begin
        if (wr_pend) lb_mem[wr_col] <= fb_rd_data;
    end

    // replay side, cleared at hblank and held until the line wraps
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rp_col  <= '0;
            rp_sub  <= '0;
            lb_cidx <= '0;
        end else begin
            if (tim.line) begin
                rp_col <= '0;
                rp_sub <= '0;
            end else if (rp_step) begin
                if (rp_sub == SUBW'(FB_SCALE - 1)) begin
                    rp_sub <= '0;
                    if (rp_col != COLW'(FB_WIDTH - 1)) rp_col <= rp_col + 1'b1;  // hold at end
                end else begin
                    rp_sub <= rp_sub + 1'b1;
                end
            end
            lb_cidx <= lb_valid ? lb_mem[rp_col] : '0;  // index 0 before first fill
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_paint.sv
// pixel paint stage
// palette lookup, image/background/blanking select and video register

`default_nettype none

module pixel_paint #(
    parameter int                 FB_WIDTH  = 16,
    parameter int                 FB_HEIGHT = 10,
    parameter int                 FB_SCALE  = 3,
    parameter fbscale_pkg::colr_t BG_COLR   = 12'h137  // outside the image
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  fbscale_pkg::timing_t tim,
    input  fbscale_pkg::cidx_t   lb_cidx,
    input  fbscale_pkg::pal_wr_t pal_wr,
    output fbscale_pkg::video_t  video
);
    import fbscale_pkg::*;

    localparam int     CLUT_SIZE = 1 << CIDXW;
    localparam coord_t IMG_W     = coord_t'(FB_WIDTH * FB_SCALE);   // scaled width
    localparam coord_t IMG_H     = coord_t'(FB_HEIGHT * FB_SCALE);  // scaled height

    colr_t   clut [CLUT_SIZE];  // colour lookup table
    colr_t   clut_colr;         // looked-up colour, stage 1
    timing_t tim_d1;            // timing aligned with clut_colr
    logic    paint_area;
    colr_t   pix_colr;

    // palette writes, table starts all black
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CLUT_SIZE; i++) begin
                clut[i] <= '0;
            end
        end else if (pal_wr.we) begin
            clut[pal_wr.idx] <= pal_wr.colr;
        end
    end

    // registered lookup
    always_ff @(posedge clk_sys) begin
        clut_colr <= clut[lb_cidx];
    end

    // first timing delay stage
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) tim_d1 <= '0;
        else        tim_d1 <= tim;
    end

    always_comb begin
        paint_area = (tim_d1.sx < IMG_W) && (tim_d1.sy < IMG_H);
        if (!tim_d1.de)     pix_colr = '0;         // black in blanking
        else if (paint_area) pix_colr = clut_colr;
        else                 pix_colr = BG_COLR;
    end

    // second stage, video out
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.colr  <= pix_colr;
            video.hsync <= tim_d1.hsync;
            video.vsync <= tim_d1.vsync;
            video.de    <= tim_d1.de;
        end
    end

endmodule

`default_nettype wire

// File: src/fbscale_top.sv
// scaled framebuffer display top level
// timing and line fetch run side by side, pixel paint merges them

`default_nettype none

module fbscale_top #(
    parameter int                 H_ACTIVE  = 48,
    parameter int                 H_TOTAL   = 80,
    parameter int                 HS_START  = 52,
    parameter int                 HS_END    = 60,
    parameter int                 V_ACTIVE  = 36,
    parameter int                 V_TOTAL   = 40,
    parameter int                 VS_START  = 37,
    parameter int                 VS_END    = 39,
    parameter int                 FB_WIDTH  = 16,   // framebuffer width
    parameter int                 FB_HEIGHT = 10,   // framebuffer height
    parameter int                 FB_SCALE  = 3,    // integer display scale
    parameter fbscale_pkg::colr_t BG_COLR   = 12'h137
) (
    input  logic                                   clk_sys,
    input  logic                                   rst_n,
    input  logic                                   fb_we,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] fb_addr,  // row*FB_WIDTH + column
    input  fbscale_pkg::cidx_t                     fb_data,
    input  fbscale_pkg::pal_wr_t                   pal_wr,
    output fbscale_pkg::video_t                    video
);
    import fbscale_pkg::*;

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    timing_t             tim;         // shared screen timing
    logic [FB_ADDRW-1:0] fb_rd_addr;
    cidx_t               fb_rd_data;
    cidx_t               lb_cidx;     // scaled index, one cycle after tim

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .HS_START(HS_START), .HS_END(HS_END),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .VS_START(VS_START), .VS_END(VS_END)
    ) i_display_timing (
        .clk_sys,
        .rst_n,
        .tim
    );

    framebuffer_ram #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_framebuffer_ram (
        .clk_sys,
        .we(fb_we),
        .addr_write(fb_addr),
        .data_in(fb_data),
        .addr_read(fb_rd_addr),
        .data_out(fb_rd_data)
    );

    line_fetch #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) i_line_fetch (
        .clk_sys,
        .rst_n,
        .tim,
        .fb_rd_addr,
        .fb_rd_data,
        .lb_cidx
    );

    pixel_paint #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE), .BG_COLR(BG_COLR)
    ) i_pixel_paint (
        .clk_sys,
        .rst_n,
        .tim,
        .lb_cidx,
        .pal_wr,
        .video  // two cycles after tim
    );

endmodule

`default_nettype wire

// File: sim/fbscale_checker.sv
// video output checker
// bound into pixel_paint, watches the registered video bundle

`default_nettype none

module fbscale_checker (
    input logic                clk_sys,
    input logic                rst_n,
    input fbscale_pkg::video_t video
);

    int unsigned fail_black;
    int unsigned fail_sync;
    int unsigned fail_reset;
    int unsigned fail_cnt;     // read by the testbench
    logic        in_reset_d;   // previous edge was in reset

    initial begin
        fail_black = 0;
        fail_sync  = 0;
        fail_reset = 0;
    end

    assign fail_cnt = fail_black + fail_sync + fail_reset;

    always_ff @(posedge clk_sys) in_reset_d <= !rst_n;

    // no colour outside the active region
    black_in_blank: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !video.de |-> (video.colr == '0))
        else begin
            fail_black++;
            $error("colour not black while de is low");
        end

    // hsync lives in horizontal blanking only
    sync_outside_de: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(video.hsync && video.de))
        else begin
            fail_sync++;
            $error("hsync and de high together");
        end

    de_low_in_reset: assert property (@(posedge clk_sys)
        (!rst_n && in_reset_d) |-> !video.de)
        else begin
            fail_reset++;
            $error("de high during reset");
        end

endmodule

bind pixel_paint fbscale_checker i_fbscale_checker (
    .clk_sys(clk_sys),
    .rst_n(rst_n),
    .video(video)
);

`default_nettype wire

// File: sim/tb_fbscale.sv
// testbench for the scaled framebuffer display pipeline
// random image and palette checked against a reference model over frames 3 to 5

`default_nettype none

module tb_fbscale;
    import fbscale_pkg::*;

    // display geometry
    localparam int H_ACTIVE  = 48;
    localparam int H_TOTAL   = 80;
    localparam int HS_START  = 52;
    localparam int HS_END    = 60;
    localparam int V_ACTIVE  = 36;
    localparam int V_TOTAL   = 40;
    localparam int VS_START  = 37;
    localparam int VS_END    = 39;
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 10;
    localparam int FB_SCALE  = 3;
    localparam colr_t BG_COLR = 12'h137;

    localparam int FB_PIXELS    = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW     = $clog2(FB_PIXELS);
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 5;                   // after rising edge
    localparam int RESET_CYCLES = 4;
    localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;   // clocks per frame
    localparam int LATENCY      = 2;                   // tim to video
    localparam int FIRST_FRAME  = 3;                   // frames counted from 1
    localparam int LAST_FRAME   = 5;
    localparam int RUN_FRAMES   = 6;
    localparam int WATCHDOG_TIME = RUN_FRAMES * FRAME_CYC * CLK_PERIOD;
    localparam int REWRITE_LINE = 37;  // inside vblank of frame 3
    localparam int REWRITE_ROW  = 4;
    localparam int REWRITE_IDX  = 5;

    localparam int T_RESET  = 1;
    localparam int T_SYNC   = 2;
    localparam int T_IMAGE  = 3;
    localparam int T_BG     = 4;
    localparam int T_UPDATE = 5;
    localparam int NUM_TESTS = 5;

    logic                clk_sys;
    logic                rst_n;
    logic                fb_we;
    logic [FB_ADDRW-1:0] fb_addr;
    cidx_t               fb_data;
    pal_wr_t             pal_wr;
    video_t              video;

    cidx_t  fb_ref [FB_PIXELS];  // copy of the framebuffer
    colr_t  pal_ref [16];        // copy of the CLUT
    integer seed;
    int     cyc;                 // clock edges since reset release
    int     err_cnt [1:NUM_TESTS];
    int     chk_cnt [1:NUM_TESTS];

    fbscale_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .HS_START(HS_START), .HS_END(HS_END),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .VS_START(VS_START), .VS_END(VS_END),
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE), .BG_COLR(BG_COLR)
    ) i_fbscale_top (
        .clk_sys,
        .rst_n,
        .fb_we,
        .fb_addr,
        .fb_data,
        .pal_wr,
        .video
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // edge n after release puts screen pixel n-1 on tim
    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) cyc <= 0;
        else        cyc <= cyc + 1;
    end

    // expected video for one screen position
    function automatic video_t expected_video(input int sx, input int sy);
        video_t v;
        int     fb_x;
        int     fb_y;
        fb_x    = sx / FB_SCALE;  // each pixel repeated FB_SCALE times
        fb_y    = sy / FB_SCALE;
        v.hsync = (sx >= HS_START) && (sx < HS_END);
        v.vsync = (sy >= VS_START) && (sy < VS_END);
        v.de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        if (!v.de) begin
            v.colr = '0;
        end else if (fb_x < FB_WIDTH && fb_y < FB_HEIGHT) begin
            v.colr = pal_ref[fb_ref[fb_y * FB_WIDTH + fb_x]];
        end else begin
            v.colr = BG_COLR;  // inside de but off the image
        end
        return v;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] actual,
                               input logic [31:0] expected, input int test);
        chk_cnt[test]++;
        if (actual !== expected) begin
            err_cnt[test]++;
            $display("ERR %0t %s actual 'h%0h expected 'h%0h", $time, sig, actual, expected);
        end
    endtask

    task automatic drive_idle();
        fb_we   = 1'b0;
        fb_addr = '0;
        fb_data = '0;
        pal_wr  = '0;
    endtask

    // returns DRIVE_DLY after the edge where cyc reaches target
    task automatic wait_cycle(input int target);
        while (cyc < target) begin
            @(posedge clk_sys);
            #DRIVE_DLY;
        end
    endtask

    // whole framebuffer plus the palette alongside the first 16 entries
    task automatic load_memories();
        logic [31:0] r_pix;
        logic [31:0] r_pal;
        for (int i = 0; i < FB_PIXELS; i++) begin
            r_pix     = $random(seed);
            fb_we     = 1'b1;
            fb_addr   = FB_ADDRW'(i);
            fb_data   = r_pix[CIDXW-1:0];
            fb_ref[i] = r_pix[CIDXW-1:0];
            if (i < 16) begin
                r_pal       = $random(seed);
                pal_wr.we   = 1'b1;
                pal_wr.idx  = cidx_t'(i);
                pal_wr.colr = r_pal[COLRW-1:0];
                pal_ref[i]  = r_pal[COLRW-1:0];
            end else begin
                pal_wr.we = 1'b0;
            end
            @(posedge clk_sys);
            #DRIVE_DLY;
        end
        drive_idle();
    endtask

    // new palette colour plus one row of ramp indices
    task automatic rewrite_row_and_palette();
        colr_t new_colr;
        new_colr    = pal_ref[REWRITE_IDX] ^ 12'hfff;  // every channel changes
        pal_wr.we   = 1'b1;
        pal_wr.idx  = cidx_t'(REWRITE_IDX);
        pal_wr.colr = new_colr;
        pal_ref[REWRITE_IDX] = new_colr;
        for (int c = 0; c < FB_WIDTH; c++) begin
            fb_we   = 1'b1;
            fb_addr = FB_ADDRW'(REWRITE_ROW * FB_WIDTH + c);
            fb_data = cidx_t'(c);
            fb_ref[REWRITE_ROW * FB_WIDTH + c] = cidx_t'(c);
            @(posedge clk_sys);
            #DRIVE_DLY;
            pal_wr.we = 1'b0;  // single palette write
        end
        drive_idle();
    endtask

    task automatic report_test(input int test, input string name);
        if (chk_cnt[test] == 0) begin
            $display("test %0d %s: no checks were made", test, name);
        end else if (err_cnt[test] == 0) begin
            $display("test %0d %s: ok, %0d checks", test, name, chk_cnt[test]);
        end else begin
            $display("test %0d %s: %0d of %0d checks wrong", test, name, err_cnt[test],
                     chk_cnt[test]);
        end
    endtask

    // compare at the falling edge where video has settled
    always @(negedge clk_sys) begin : compare
        int     p;
        int     frm;
        int     sx;
        int     sy;
        int     test;
        video_t exp_v;
        if (rst_n && cyc >= 1) begin
            if (cyc <= LATENCY) begin
                check_value("video", 32'(video), 32'(0), T_RESET);  // pipeline still filling
            end else begin
                p   = cyc - LATENCY - 1;
                frm = p / FRAME_CYC + 1;
                if (frm >= FIRST_FRAME && frm <= LAST_FRAME) begin
                    sx    = p % H_TOTAL;
                    sy    = (p / H_TOTAL) % V_TOTAL;
                    exp_v = expected_video(sx, sy);
                    check_value("video.hsync", 32'(video.hsync), 32'(exp_v.hsync), T_SYNC);
                    check_value("video.vsync", 32'(video.vsync), 32'(exp_v.vsync), T_SYNC);
                    check_value("video.de", 32'(video.de), 32'(exp_v.de), T_SYNC);
                    if (exp_v.de && sx < FB_WIDTH * FB_SCALE && sy < FB_HEIGHT * FB_SCALE)
                        test = (frm == FIRST_FRAME) ? T_IMAGE : T_UPDATE;
                    else
                        test = T_BG;  // background or blanking
                    check_value("video.colr", 32'(video.colr), 32'(exp_v.colr), test);
                end
            end
        end
    end

    initial begin : main
        int total_chk;
        int total_err;
        int idle_tests;
        int assert_fails;
        clk_sys = 1'b0;
        rst_n   = 1'b0;
        seed    = 32'hc0691a72;
        drive_idle();
        for (int t = 1; t <= NUM_TESTS; t++) begin
            err_cnt[t] = 0;
            chk_cnt[t] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #DRIVE_DLY;
        check_value("video", 32'(video), 32'(0), T_RESET);  // held in reset
        rst_n = 1'b1;
        wait_cycle(1);
        load_memories();  // well inside frame 1
        report_test(T_RESET, "reset and pipeline start");
        wait_cycle((FIRST_FRAME - 1) * FRAME_CYC + REWRITE_LINE * H_TOTAL + 1);
        rewrite_row_and_palette();
        wait_cycle(FIRST_FRAME * FRAME_CYC + LATENCY + 1);
        report_test(T_IMAGE, "scaled image");
        wait_cycle(LAST_FRAME * FRAME_CYC + LATENCY + 1);
        report_test(T_SYNC, "sync and de window");
        report_test(T_BG, "background and blanking");
        report_test(T_UPDATE, "palette and row rewrite");
        total_chk  = 0;
        total_err  = 0;
        idle_tests = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            total_chk += chk_cnt[t];
            total_err += err_cnt[t];
            if (chk_cnt[t] == 0) idle_tests++;
        end
        assert_fails = i_fbscale_top.i_pixel_paint.i_fbscale_checker.fail_cnt;
        $display("checks %0d, errors %0d, tests without checks %0d, assertion failures %0d",
                 total_chk, total_err, idle_tests, assert_fails);
        if (total_err == 0 && idle_tests == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: run still going after %0d frames", RUN_FRAMES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/fbscale_pkg.sv
src/display_timing.sv
src/framebuffer_ram.sv
src/line_fetch.sv
src/pixel_paint.sv
src/fbscale_top.sv
sim/fbscale_checker.sv
sim/tb_fbscale.sv

// File: Makefile
# Verilator build and run for the scaled framebuffer pipeline

VERILATOR ?= verilator
TOP       ?= tb_fbscale
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
